// File: Bender.yml
package:
  name: lrelu_coef_unit

sources:
  - logic/lrelu_pkg.sv
  - logic/lrelu_cfg_regs.sv
  - logic/coef_bram.sv
  - logic/always_valid_cyclic_bram.sv
  - logic/lrelu_scaler.sv
  - logic/lrelu_coef_unit.sv
  - target: simulation
    files:
      - sim/tb_lrelu_coef_unit.sv

// File: logic/always_valid_cyclic_bram.sv
module always_valid_cyclic_bram (
  input  logic                         clk,
  input  logic                         clken,
  input  logic                         rst,
  input  logic                         restart,
  input  lrelu_pkg::cfg_t              cfg,
  input  lrelu_pkg::coef_wr_t          coef_wr,
  output logic [lrelu_pkg::COEF_W-1:0] coef,
  output logic                         coef_valid,
  input  logic                         coef_take
);

  enum logic [1:0] {S_WRITE, S_FILL1, S_FILL2, S_READ} state, state_next;

  logic [lrelu_pkg::ADDR_W-1:0] w_addr;
  logic [lrelu_pkg::ADDR_W-1:0] r_addr;
  logic [lrelu_pkg::PTR_W-1:0]  w_ptr;
  logic [lrelu_pkg::PTR_W-1:0]  r_ptr;
  logic [lrelu_pkg::PTR_W:0]    used;      // entries held in the buffer
  logic                         ram_we;
  logic                         ram_re;
  logic                         last_wr;
  logic                         rvalid;
  logic                         land;
  logic                         take;
  logic [lrelu_pkg::COEF_W-1:0] rdata;
  logic [lrelu_pkg::COEF_W-1:0] buf_q [lrelu_pkg::BUF_DEPTH];

  function automatic logic [lrelu_pkg::PTR_W-1:0] ptr_inc(
    input logic [lrelu_pkg::PTR_W-1:0] p
  );
    return (p == lrelu_pkg::BUF_DEPTH - 1) ? '0 : p + 1'b1;
  endfunction

  assign ram_we  = (state == S_WRITE) && coef_wr.valid;  // late loads fall on the floor
  assign last_wr = ram_we && (w_addr == cfg.table_len_m1);
  assign take    = coef_take && coef_valid;
  assign land    = rvalid && (state != S_WRITE);  // reads still in flight at restart are dropped

  always_comb begin
    state_next = state;
    unique case (state)
      S_WRITE: if (last_wr) state_next = S_FILL1;
      S_FILL1: if (rvalid) state_next = S_FILL2;
      S_FILL2: if (land && w_ptr == lrelu_pkg::BUF_DEPTH - 1) state_next = S_READ;
      S_READ:  state_next = S_READ;
    endcase
  end

  // fill1 lasts exactly latency+1 cycles, which issues one read per buffer entry.
  // after that every take is replaced by one new read, so entries plus reads in
  // flight stay at BUF_DEPTH and the buffer is never empty while valid
  always_comb begin
    unique case (state)
      S_FILL1:         ram_re = 1'b1;
      S_FILL2, S_READ: ram_re = take;
      default:         ram_re = 1'b0;
    endcase
  end

  assign coef_valid = (state == S_FILL2) || (state == S_READ);

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      state  <= S_WRITE;
      w_addr <= '0;
      r_addr <= '0;
      w_ptr  <= '0;
      r_ptr  <= '0;
      used   <= '0;
    end else if (clken) begin
      state <= state_next;
      if (ram_we) begin
        w_addr <= last_wr ? '0 : w_addr + 1'b1;
      end
      if (ram_re) begin
        r_addr <= (r_addr == cfg.table_len_m1) ? '0 : r_addr + 1'b1;  // cyclic table
      end
      if (land) w_ptr <= ptr_inc(w_ptr);
      if (take) r_ptr <= ptr_inc(r_ptr);
      if (land && !take) begin
        used <= used + 1'b1;
      end else if (take && !land) begin
        used <= used - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken && land) begin
      buf_q[w_ptr] <= rdata;
    end
  end

  assign coef = buf_q[r_ptr];  // next coefficient straight from the buffer

  coef_bram u_ram (
    .clk    (clk),
    .clken  (clken),
    .we     (ram_we),
    .waddr  (w_addr),
    .wdata  (coef_wr.coef),
    .re     (ram_re),
    .raddr  (r_addr),
    .rdata  (rdata),
    .rvalid (rvalid)
  );

  // the scaler qualifies its take with our valid
  a_take_when_valid: assert property (
    @(posedge clk) disable iff (rst)
    coef_take |-> coef_valid
  ) else $error("coefficient taken while none is valid");

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst || restart)
    land |-> (used != lrelu_pkg::BUF_DEPTH)
  ) else $error("ram data arrived with the buffer full");

endmodule

// File: logic/coef_bram.sv
module coef_bram (
  input  logic                         clk,
  input  logic                         clken,
  input  logic                         we,
  input  logic [lrelu_pkg::ADDR_W-1:0] waddr,
  input  logic [lrelu_pkg::COEF_W-1:0] wdata,
  input  logic                         re,
  input  logic [lrelu_pkg::ADDR_W-1:0] raddr,
  output logic [lrelu_pkg::COEF_W-1:0] rdata,
  output logic                         rvalid
);

  logic [lrelu_pkg::COEF_W-1:0] mem [lrelu_pkg::DEPTH];

  // output register chain, last stage is the ram output
  logic [lrelu_pkg::COEF_W-1:0] rd_pipe [lrelu_pkg::BRAM_LATENCY];

  // read strobe travels beside the data so rvalid cannot drift from rdata
  logic [lrelu_pkg::BRAM_LATENCY-1:0] re_pipe = '0;

  always_ff @(posedge clk) begin
    if (clken && we) begin
      mem[waddr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      rd_pipe[0] <= mem[raddr];
      for (int i = 1; i < lrelu_pkg::BRAM_LATENCY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      re_pipe <= {re_pipe[lrelu_pkg::BRAM_LATENCY-2:0], re};
    end
  end

  assign rdata  = rd_pipe[lrelu_pkg::BRAM_LATENCY-1];
  assign rvalid = re_pipe[lrelu_pkg::BRAM_LATENCY-1];

endmodule

// File: logic/lrelu_cfg_regs.sv
module lrelu_cfg_regs (
  input  logic            clk,
  input  logic            rst,
  input  logic            cfg_we,
  input  logic            cfg_addr,
  input  logic [7:0]      cfg_wdata,
  output lrelu_pkg::cfg_t cfg,
  output logic            restart
);

  // address 0 is the table length, address 1 the fraction shift
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.table_len_m1 <= lrelu_pkg::LAST_ADDR;
      cfg.frac_shift   <= '0;
    end else if (cfg_we) begin
      if (cfg_addr) begin
        cfg.frac_shift <= cfg_wdata[lrelu_pkg::SHIFT_W-1:0];
      end else begin
        cfg.table_len_m1 <= cfg_wdata[lrelu_pkg::ADDR_W-1:0];
      end
    end
  end

  // a new length invalidates the loaded table, so the reader starts over
  always_ff @(posedge clk) begin
    if (rst) begin
      restart <= 1'b0;
    end else begin
      restart <= cfg_we && !cfg_addr;  // lands together with the new length
    end
  end

  // the host must leave a gap between length writes, or the reader
  // would see a restart while it is still clearing
  a_restart_single: assert property (
    @(posedge clk) disable iff (rst)
    restart |=> !restart
  ) else $error("restart held for more than one cycle");

endmodule

// File: logic/lrelu_coef_unit.sv
module lrelu_coef_unit (
  input  logic                clk,
  input  logic                clken,
  input  logic                rst,
  input  logic                cfg_we,
  input  logic                cfg_addr,
  input  logic [7:0]          cfg_wdata,
  input  lrelu_pkg::coef_wr_t coef_wr,
  input  lrelu_pkg::act_t     act,
  output logic                ready,
  output lrelu_pkg::res_t     res
);

  lrelu_pkg::cfg_t              cfg;
  logic                         restart;
  logic [lrelu_pkg::COEF_W-1:0] coef;
  logic                         coef_valid;
  logic                         coef_take;

  lrelu_cfg_regs u_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg),
    .restart   (restart)
  );

  always_valid_cyclic_bram u_reader (
    .clk        (clk),
    .clken      (clken),
    .rst        (rst),
    .restart    (restart),
    .cfg        (cfg),
    .coef_wr    (coef_wr),
    .coef       (coef),
    .coef_valid (coef_valid),
    .coef_take  (coef_take)
  );

  lrelu_scaler u_scaler (
    .clk        (clk),
    .clken      (clken),
    .rst        (rst),
    .cfg        (cfg),
    .act        (act),
    .coef       (coef),
    .coef_valid (coef_valid),
    .coef_take  (coef_take),
    .ready      (ready),
    .res        (res)
  );

endmodule

// File: logic/lrelu_pkg.sv
package lrelu_pkg;

  // coefficient table
  localparam int DEPTH   = 64;
  localparam int ADDR_W  = $clog2(DEPTH);
  localparam int COEF_W  = 8;   // signed slope, fraction bits set by frac_shift

  // datapath
  localparam int ACT_W   = 8;
  localparam int OUT_W   = 16;  // holds the full act * coef product
  localparam int SHIFT_W = 3;

  // ram read path and the buffer hiding it
  localparam int BRAM_LATENCY = 3;
  localparam int BUF_DEPTH    = BRAM_LATENCY + 1;
  localparam int PTR_W        = $clog2(BUF_DEPTH);

  // reset value of the length field, a full table
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

  typedef struct packed {
    logic [ADDR_W-1:0]  table_len_m1;  // last table address
    logic [SHIFT_W-1:0] frac_shift;
  } cfg_t;

  // host load strobe with its coefficient
  typedef struct packed {
    logic              valid;
    logic [COEF_W-1:0] coef;
  } coef_wr_t;

  typedef struct packed {
    logic             valid;
    logic [ACT_W-1:0] data;
  } act_t;

  typedef struct packed {
    logic             valid;
    logic [OUT_W-1:0] data;
  } res_t;

endpackage

// File: logic/lrelu_scaler.sv
module lrelu_scaler (
  input  logic                         clk,
  input  logic                         clken,
  input  logic                         rst,
  input  lrelu_pkg::cfg_t              cfg,
  input  lrelu_pkg::act_t              act,
  input  logic [lrelu_pkg::COEF_W-1:0] coef,
  input  logic                         coef_valid,
  output logic                         coef_take,
  output logic                         ready,
  output lrelu_pkg::res_t              res
);

  localparam int EXT_W = lrelu_pkg::OUT_W - lrelu_pkg::ACT_W;

  logic                               act_neg;
  logic signed [lrelu_pkg::OUT_W-1:0] act_ext;
  logic signed [lrelu_pkg::OUT_W-1:0] prod;
  logic signed [lrelu_pkg::OUT_W-1:0] scaled;
  logic signed [lrelu_pkg::OUT_W-1:0] result;

  // an activation is only accepted when a coefficient is there for it
  assign coef_take = act.valid && coef_valid;
  assign ready     = coef_valid;

  assign act_neg = act.data[lrelu_pkg::ACT_W-1];
  assign act_ext = {{EXT_W{act_neg}}, act.data};

  // full width signed product, then drop the fraction bits of the slope
  assign prod   = $signed(act.data) * $signed(coef);
  assign scaled = prod >>> cfg.frac_shift;

  assign result = act_neg ? scaled : act_ext;  // positives pass through

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else if (clken) begin
      res.valid <= coef_take;
    end
  end

  always_ff @(posedge clk) begin
    if (clken && coef_take) begin
      res.data <= result;
    end
  end

  // an accepted activation gives a result with known data one cycle later
  a_res_timing: assert property (
    @(posedge clk) disable iff (rst)
    (clken && coef_take) |=> (res.valid && !$isunknown(res.data))
  ) else $error("accepted activation gave no defined result one cycle later");

endmodule

// File: sim/lrelu_tests.txt
// one hex word per record: kind digit _ 8-bit field _ 16-bit field
// 1 cfg write (addr, data)  2 coef load (-, coef)  3 activation (act, -)  4 expected (-, result)

// table of eight slopes, shift 2
1_00_0007 1_01_0002
2_00_0004 2_00_0008 2_00_0002 2_00_0010
2_00_0001 2_00_000C 2_00_00FC 2_00_0020
3_05_0000 4_00_0005
3_7F_0000 4_00_007F
3_F0_0000 4_00_FFF8
3_80_0000 4_00_FE00
3_FF_0000 4_00_FFFF
3_E7_0000 4_00_FFB5
3_CE_0000 4_00_0032
3_9C_0000 4_00_FCE0
// back to the first slope
3_FD_0000 4_00_FFFD
3_00_0000 4_00_0000
3_F9_0000 4_00_FFFC

// new length restarts the reader, four slopes, shift 1
1_00_0003 1_01_0001
2_00_0006 2_00_00FE 2_00_0040 2_00_0003
3_F6_0000 4_00_FFE2
3_EC_0000 4_00_0014
3_81_0000 4_00_F020
3_33_0000 4_00_0033
3_FB_0000 4_00_FFF1
3_FF_0000 4_00_0001

// File: sim/tb_lrelu_coef_unit.sv
module tb_lrelu_coef_unit;
  timeunit 1ns;
  timeprecision 1ps;

  logic                clk;
  logic                clken;
  logic                rst;
  logic                cfg_we;
  logic                cfg_addr;
  logic [7:0]          cfg_wdata;
  lrelu_pkg::coef_wr_t coef_wr;
  lrelu_pkg::act_t     act;
  logic                ready;
  lrelu_pkg::res_t     res;

  logic [27:0]     recs [64];  // kind, 8-bit field, 16-bit field
  int              n_rec = 0;
  int              ri;
  int              n_checks = 0;
  int              n_errors = 0;
  logic [7:0]      table_q [$];  // slopes in load order
  int              next_idx = 0;
  int              shift = 0;
  lrelu_pkg::res_t pend;         // result due at the next check
  string           pend_what;
  logic [3:0]      kind;
  logic [3:0]      prev_kind;

  lrelu_coef_unit UUT (
    .clk       (clk),
    .clken     (clken),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .coef_wr   (coef_wr),
    .act       (act),
    .ready     (ready),
    .res       (res)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // leaky relu: positives pass, negatives scaled by slope then shifted
  function automatic logic [15:0] leaky_ref(input logic signed [7:0] a,
                                            input logic signed [7:0] c, input int sh);
    int p;
    if (a >= 0) return 16'(int'(a));
    p = int'(a) * int'(c);
    return 16'(p >>> sh);
  endfunction

  task automatic check_res(input lrelu_pkg::res_t exp, input string what);
    n_checks++;
    if (res.valid !== exp.valid || (exp.valid && res.data !== exp.data)) begin
      n_errors++;
      $display("Fail %0t: %s, expected valid %0b data %h, got valid %0b data %h",
               $time, what, exp.valid, exp.data, res.valid, res.data);
    end
  endtask

  task automatic check_ready(input logic exp, input string what);
    n_checks++;
    if (ready !== exp) begin
      n_errors++;
      $display("Fail %0t: %s, expected ready %0b, got %0b", $time, what, exp, ready);
    end
  endtask

  function automatic void advance_coef();
    next_idx = (next_idx + 1) % table_q.size();
  endfunction

  // one cycle of the activation stream, checks the result of the previous one
  task automatic act_cycle(input logic v, input logic [7:0] a,
                           input lrelu_pkg::res_t exp, input string what);
    @(posedge clk);
    act     <= {v, a};
    coef_wr <= '0;
    @(negedge clk);
    check_res(pend, pend_what);
    pend      = exp;
    pend_what = what;
  endtask

  task automatic write_cfg(input logic addr, input logic [7:0] data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    act       <= '0;
    coef_wr   <= '0;
    @(negedge clk);
    check_res(pend, pend_what);
    pend = '0;
    pend_what = "idle cycle";
    @(posedge clk);
    cfg_we <= 1'b0;
    if (!addr) begin
      table_q.delete();
      next_idx = 0;
      @(posedge clk);
      @(negedge clk);
      check_ready(1'b0, "ready after a length write");
    end else begin
      shift = data[2:0];
    end
  endtask

  // an activation rides along with each load and must be dropped
  task automatic load_coef(input logic [7:0] c);
    @(posedge clk);
    coef_wr <= {1'b1, c};
    act     <= {1'b1, 8'($urandom)};
    @(negedge clk);
    check_res(pend, pend_what);
    check_ready(1'b0, "ready while loading");
    pend      = '0;
    pend_what = "activation during load";
    table_q.push_back(c);
  endtask

  task automatic settle_and_wait_ready();
    int tries;
    tries = 0;
    @(posedge clk);
    act     <= '0;
    coef_wr <= '0;
    @(negedge clk);
    check_res(pend, pend_what);
    pend = '0;
    pend_what = "idle cycle";
    while (!ready && tries < 40) begin
      @(negedge clk);
      tries++;
    end
    if (!ready) begin
      n_errors++;
      $display("ready did not rise within 40 cycles after the table was loaded");
    end
  endtask

  task automatic run_file_act(input logic [7:0] a, input logic [15:0] exp, input int idx);
    int gap;
    if (leaky_ref(a, table_q[next_idx], shift) !== exp) begin
      n_errors++;
      $display("data file expectation at record %0d disagrees with the leaky relu rule", idx);
    end
    act_cycle(1'b1, a, {1'b1, exp}, $sformatf("activation record %0d", idx));
    advance_coef();
    gap = $urandom_range(0, 2);  // holes in the stream must not skip slopes
    repeat (gap) act_cycle(1'b0, 8'h00, '0, "gap cycle");
  endtask

  task automatic run_random(input int n);
    logic            v;
    logic [7:0]      a;
    lrelu_pkg::res_t exp;
    for (int k = 0; k < n; k++) begin
      v   = ($urandom_range(0, 3) != 0);
      a   = 8'($urandom);
      exp = '0;
      if (v) begin
        exp = {1'b1, leaky_ref(a, table_q[next_idx], shift)};
        advance_coef();
      end
      act_cycle(v, a, exp, "random activation");
    end
  endtask

  // held activation under clken low, taken once clken returns
  task automatic check_clken_hold();
    logic [7:0]      a;
    lrelu_pkg::res_t exp;
    a   = {1'b1, 7'($urandom)};
    exp = {1'b1, leaky_ref(a, table_q[next_idx], shift)};
    act_cycle(1'b0, 8'h00, '0, "idle before clken test");
    @(posedge clk);
    clken <= 1'b0;
    act   <= {1'b1, a};
    @(negedge clk);
    check_res(pend, pend_what);
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_res('0, "result while clken is low");
    end
    check_ready(1'b1, "ready while clken is low");
    @(posedge clk);
    clken <= 1'b1;
    @(negedge clk);
    check_res('0, "result while clken is low");
    pend      = exp;
    pend_what = "held activation after clken";
    advance_coef();
  endtask

  initial begin
    wait (n_rec > 0);
    #((n_rec * 20 + 200) * 8);
    $display("watchdog expired, the run did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(44084));
    rst       = 1'b1;
    clken     = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    coef_wr   = '0;
    act       = '0;
    pend      = '0;
    pend_what = "idle cycle";
    prev_kind = 4'h0;
    for (int i = 0; i < 64; i++) recs[i] = '0;
    $readmemh("sim/lrelu_tests.txt", recs);
    while (n_rec < 64 && recs[n_rec][27:24] != 4'h0) n_rec++;

    if (n_rec == 0) begin
      n_errors++;
      $display("no test records could be read from sim/lrelu_tests.txt");
    end else begin
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      ri = 0;
      while (ri < n_rec) begin
        kind = recs[ri][27:24];
        case (kind)
          4'h1: write_cfg(recs[ri][16], recs[ri][7:0]);
          4'h2: load_coef(recs[ri][7:0]);
          4'h3: begin
            if (prev_kind == 4'h2) settle_and_wait_ready();
            if (ri + 1 >= n_rec || recs[ri+1][27:24] != 4'h4) begin
              n_errors++;
              $display("activation record %0d has no expected result after it", ri);
            end else begin
              run_file_act(recs[ri][23:16], recs[ri+1][15:0], ri);
              ri++;
            end
          end
          default: begin
            n_errors++;
            $display("record %0d has unknown kind %0h", ri, kind);
          end
        endcase
        prev_kind = kind;
        ri++;
      end
      run_random(12);
      check_clken_hold();
      run_random(6);
      act_cycle(1'b0, 8'h00, '0, "final idle");
    end

    $display("checks run %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
logic/lrelu_pkg.sv
logic/lrelu_cfg_regs.sv
logic/coef_bram.sv
logic/always_valid_cyclic_bram.sv
logic/lrelu_scaler.sv
logic/lrelu_coef_unit.sv
sim/tb_lrelu_coef_unit.sv
